// File: bench/blob_golden.txt
// width height bg left top rect_w rect_h colour r_lo r_hi g_lo g_hi b_lo b_hi exp_x exp_y mode
// all hex; mode 0 result, 1 no result, 2 reset mid-frame then result
// red square on black, centre 6.5,4.5 floored
10 0C 0000 05 03 04 04 F800 C0 FF 00 3F 00 3F 06 04 0
// bounds exact at the field values A0/80/50
10 0C 0000 02 01 05 03 A40A A0 A0 80 80 50 50 04 02 0
// same rectangle with wider bounds
10 0C 0000 02 01 05 03 A40A 90 B0 70 90 40 60 04 02 0
// rectangle fails green only
10 0C 0000 02 01 05 03 A40A 90 B0 90 FF 40 60 00 00 1
// nothing in the frame passes
10 0C 0000 04 04 03 03 0000 C0 FF 00 3F 00 3F 00 00 1
// rectangle in the top-left corner
0C 08 0000 00 00 03 06 F800 C0 FF 00 3F 00 3F 01 02 0
// two blue frames back to back
10 0A 0000 09 06 02 02 001F 00 3F 00 3F C0 FF 09 06 0
10 0A 0000 01 02 06 02 001F 00 3F 00 3F C0 FF 03 02 0
// green background around a black band on top
08 06 07E0 00 00 08 03 0000 00 3F C0 FF 00 3F 03 04 0
// reset two lines into a frame, then a full frame
10 0C 0000 0A 08 05 03 F800 C0 FF 00 3F 00 3F 0C 09 2

// File: build.f
hw/tracker_pkg.sv
hw/pixel_if.sv
hw/pixel_capture.sv
hw/channel_threshold.sv
hw/blob_centroid.sv
hw/blob_tracker_top.sv
bench/tb_clock_gen.sv
bench/tb_blob_tracker.sv

// File: run_sim.sh
#!/bin/sh
# build the blob tracker testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_blob_tracker \
    -f build.f -o tb_sim > build.log 2>&1 ||
    { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH PASSED" sim.log && exit 0 ||
    { echo "simulation did not pass"; exit 1; }

// File: bench/tb_blob_tracker.sv
`timescale 1ns/1ns

module tb_blob_tracker;

    localparam int REC_W       = 17;   // words per golden record
    localparam int MAX_TESTS   = 16;
    localparam int POR_CYCLES  = 16;   // same as tb_clock_gen
    localparam int MID_RST_CYC = 8;    // length of the mid-frame reset
    localparam int RESULT_WAIT = 200;  // x and y division take about 70 cycles

    logic clk_camera;
    logic por_reset;
    logic mid_reset;
    logic recent_reset;
    logic cam_pclk;
    logic cam_hsync;
    logic cam_vsync;
    logic [7:0] cam_data;
    logic [tracker_pkg::NUM_CHANNELS-1:0][tracker_pkg::CHAN_W-1:0] lower_bound;
    logic [tracker_pkg::NUM_CHANNELS-1:0][tracker_pkg::CHAN_W-1:0] upper_bound;
    logic [tracker_pkg::HCOUNT_W-1:0] com_x;
    logic [tracker_pkg::VCOUNT_W-1:0] com_y;
    logic com_valid;

    logic [31:0] golden_mem [MAX_TESTS*REC_W];
    int x_q[$];  // results seen on the DUT outputs
    int y_q[$];

    // current test, straight from the golden record
    int width;
    int height;
    int left;
    int top;
    int rect_w;
    int rect_h;
    int exp_x;
    int exp_y;
    int mode;  // 0 result, 1 no result, 2 reset mid-frame then result
    logic [15:0] bg_colour;
    logic [15:0] rect_colour;

    int num_tests;
    int pass_count;
    int fail_count;
    longint limit;
    logic limit_ready = 1'b0;

    assign recent_reset = por_reset | mid_reset;

    tb_clock_gen u_clock (
        .clk_o  (clk_camera),
        .reset_o(por_reset)
    );

    blob_tracker_top dut (
        .clk_camera   (clk_camera),
        .recent_reset (recent_reset),
        .cam_pclk_i   (cam_pclk),
        .cam_hsync_i  (cam_hsync),
        .cam_vsync_i  (cam_vsync),
        .cam_data_i   (cam_data),
        .lower_bound_i(lower_bound),
        .upper_bound_i(upper_bound),
        .com_x_o      (com_x),
        .com_y_o      (com_y),
        .com_valid_o  (com_valid)
    );

    always @(negedge clk_camera) begin
        if (com_valid) begin  // outputs settled half a cycle after the edge
            x_q.push_back(int'(com_x));
            y_q.push_back(int'(com_y));
        end
    end

    task automatic load_test(input int t);
        int base;
        base        = t * REC_W;
        width       = golden_mem[base + 0];
        height      = golden_mem[base + 1];
        bg_colour   = golden_mem[base + 2][15:0];
        left        = golden_mem[base + 3];
        top         = golden_mem[base + 4];
        rect_w      = golden_mem[base + 5];
        rect_h      = golden_mem[base + 6];
        rect_colour = golden_mem[base + 7][15:0];
        lower_bound[tracker_pkg::ch_red]   = golden_mem[base + 8][7:0];
        upper_bound[tracker_pkg::ch_red]   = golden_mem[base + 9][7:0];
        lower_bound[tracker_pkg::ch_green] = golden_mem[base + 10][7:0];
        upper_bound[tracker_pkg::ch_green] = golden_mem[base + 11][7:0];
        lower_bound[tracker_pkg::ch_blue]  = golden_mem[base + 12][7:0];
        upper_bound[tracker_pkg::ch_blue]  = golden_mem[base + 13][7:0];
        exp_x       = golden_mem[base + 14];
        exp_y       = golden_mem[base + 15];
        mode        = golden_mem[base + 16];
    endtask

    function automatic logic [15:0] colour_at(input int col, input int row);
        if (col >= left && col < left + rect_w && row >= top && row < top + rect_h) begin
            return rect_colour;
        end
        return bg_colour;
    endfunction

    // one camera pclk period, 3 cycles low then 3 high, starts and ends on a falling edge
    task automatic pclk_period(input logic hs, input logic vs, input logic [7:0] b);
        cam_pclk  = 1'b0;
        cam_hsync = hs;
        cam_vsync = vs;
        cam_data  = b;
        repeat (3) @(negedge clk_camera);
        cam_pclk = 1'b1;  // camera data is sampled on this edge
        repeat (3) @(negedge clk_camera);
    endtask

    task automatic send_line(input int row, input logic fill);
        logic [15:0] px;
        for (int col = 0; col < width; col++) begin
            px = fill ? rect_colour : colour_at(col, row);
            pclk_period(1'b1, 1'b0, px[15:8]);  // high byte first
            pclk_period(1'b1, 1'b0, px[7:0]);
        end
        repeat (8) pclk_period(1'b0, 1'b0, 8'h00);  // horizontal gap
    endtask

    task automatic send_frame();
        for (int row = 0; row < height; row++) begin
            send_line(row, 1'b0);
        end
        repeat (4) pclk_period(1'b0, 1'b1, 8'h00);  // vsync pulse closes the frame
        cam_vsync = 1'b0;
    endtask

    task automatic pulse_reset();
        cam_pclk  = 1'b0;
        cam_hsync = 1'b0;
        mid_reset = 1'b1;
        repeat (MID_RST_CYC) @(negedge clk_camera);
        mid_reset = 1'b0;
    endtask

    task automatic wait_result(output logic got);
        int waited;
        waited = 0;
        while (x_q.size() == 0 && waited < RESULT_WAIT) begin
            @(negedge clk_camera);
            waited++;
        end
        got = (x_q.size() != 0);
    endtask

    initial begin : watchdog
        wait (limit_ready);
        repeat (limit) @(posedge clk_camera);
        $display("run timed out after %0d cycles without finishing the tests", limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : main
        logic got;
        cam_pclk    = 1'b0;
        cam_hsync   = 1'b0;
        cam_vsync   = 1'b0;
        cam_data    = 8'h00;
        mid_reset   = 1'b0;
        lower_bound = '0;
        upper_bound = '0;
        pass_count  = 0;
        fail_count  = 0;
        for (int i = 0; i < MAX_TESTS * REC_W; i++) begin
            golden_mem[i] = 32'h0;  // a zero width ends the test list
        end
        $readmemh("bench/blob_golden.txt", golden_mem);

        num_tests = 0;
        limit     = POR_CYCLES;
        while (num_tests < MAX_TESTS && golden_mem[num_tests * REC_W] != 0) begin
            load_test(num_tests);
            limit += (width * 2 + 8) * (height + 4) * 6 + 200;
            if (mode == 2) begin
                limit += MID_RST_CYC;
            end
            num_tests++;
        end
        limit_ready = 1'b1;

        wait (!por_reset);
        @(negedge clk_camera);
        for (int t = 0; t < num_tests; t++) begin
            load_test(t);
            if (mode == 2) begin
                send_line(0, 1'b1);  // two lines of blob colour that reset must discard
                send_line(1, 1'b1);
                pulse_reset();
            end
            send_frame();
            wait_result(got);
            if (mode == 1) begin
                if (got) begin
                    $display("test %0d failed: result (%0d,%0d) came where none was expected",
                             t, x_q[0], y_q[0]);
                    fail_count++;
                end else begin
                    $display("test %0d passed, no result", t);
                    pass_count++;
                end
            end else if (!got) begin
                $display("test %0d failed: no result within %0d cycles after the frame",
                         t, RESULT_WAIT);
                fail_count++;
            end else if (x_q[0] != exp_x || y_q[0] != exp_y) begin
                $display("mismatch at %0t: test %0d expected (%0d,%0d), got (%0d,%0d)",
                         $time, t, exp_x, exp_y, x_q[0], y_q[0]);
                fail_count++;
            end else begin
                $display("test %0d passed, centroid (%0d,%0d)", t, exp_x, exp_y);
                pass_count++;
            end
            x_q.delete();
            y_q.delete();
        end

        $display("%0d tests, %0d passed, %0d failed", num_tests, pass_count, fail_count);
        if (fail_count == 0 && num_tests > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: bench/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o,    // clk_camera, 8 ns period
    output logic reset_o   // power-on reset, high for the first 16 cycles
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (16) @(posedge clk_o);
        @(negedge clk_o);  // release away from the active edge
        reset_o = 1'b0;
    end

endmodule

// File: hw/blob_tracker_top.sv
`timescale 1ns/1ns

module blob_tracker_top (
    input  logic                             clk_camera,
    input  logic                             recent_reset,
    input  logic                             cam_pclk_i,
    input  logic                             cam_hsync_i,
    input  logic                             cam_vsync_i,
    input  logic [7:0]                       cam_data_i,
    // bounds indexed by channel_e
    input  logic [tracker_pkg::NUM_CHANNELS-1:0][tracker_pkg::CHAN_W-1:0] lower_bound_i,
    input  logic [tracker_pkg::NUM_CHANNELS-1:0][tracker_pkg::CHAN_W-1:0] upper_bound_i,
    output logic [tracker_pkg::HCOUNT_W-1:0] com_x_o,
    output logic [tracker_pkg::VCOUNT_W-1:0] com_y_o,
    output logic                             com_valid_o
);

    pixel_if pix_bus ();

    logic [tracker_pkg::NUM_CHANNELS-1:0] mask;  // one bit per channel

    pixel_capture u_capture (
        .clk_camera  (clk_camera),
        .recent_reset(recent_reset),
        .cam_pclk_i  (cam_pclk_i),
        .cam_hsync_i (cam_hsync_i),
        .cam_vsync_i (cam_vsync_i),
        .cam_data_i  (cam_data_i),
        .pix         (pix_bus)
    );

    // loop index doubles as the channel select
    for (genvar i = 0; i < tracker_pkg::NUM_CHANNELS; i++) begin : g_thresh
        channel_threshold u_thresh (
            .clk_camera  (clk_camera),
            .recent_reset(recent_reset),
            .pix         (pix_bus),
            .channel     (tracker_pkg::channel_e'(i)),
            .lower_i     (lower_bound_i[i]),
            .upper_i     (upper_bound_i[i]),
            .mask_o      (mask[i])
        );
    end

    blob_centroid u_centroid (
        .clk_camera  (clk_camera),
        .recent_reset(recent_reset),
        .pix         (pix_bus),
        .mask_i      (mask),
        .com_x_o     (com_x_o),
        .com_y_o     (com_y_o),
        .com_valid_o (com_valid_o)
    );

endmodule

// File: hw/blob_centroid.sv
`timescale 1ns/1ns

module blob_centroid (
    input  logic                                 clk_camera,
    input  logic                                 recent_reset,
    pixel_if.sink                                pix,
    input  logic [tracker_pkg::NUM_CHANNELS-1:0] mask_i,
    output logic [tracker_pkg::HCOUNT_W-1:0]     com_x_o,
    output logic [tracker_pkg::VCOUNT_W-1:0]     com_y_o,
    output logic                                 com_valid_o
);

    localparam int CW = tracker_pkg::COUNT_W;
    localparam int XW = tracker_pkg::SUMX_W;
    localparam int YW = tracker_pkg::SUMY_W;

    // pixel stream delayed to line up with the registered mask bits
    logic                             valid_d;
    logic [tracker_pkg::HCOUNT_W-1:0] hcount_d;
    logic [tracker_pkg::VCOUNT_W-1:0] vcount_d;
    logic                             hit;

    logic [CW-1:0] count;
    logic [XW-1:0] sum_x;
    logic [YW-1:0] sum_y;
    logic [CW-1:0] cnt_next;  // totals including this cycle's hit
    logic [XW-1:0] sumx_next;
    logic [YW-1:0] sumy_next;

    tracker_pkg::centroid_state_e   state;
    logic [tracker_pkg::DIV_CNT_W-1:0] step;
    logic                           last_step;
    logic [XW-1:0]                  div_dividend;  // shifts out dividend, shifts in quotient
    logic [CW-1:0]                  div_rem;
    logic [CW-1:0]                  div_divisor;
    logic [YW-1:0]                  sum_y_hold;    // row sum waits while x divides
    logic [CW:0]                    rem_shift;
    logic [CW:0]                    rem_diff;
    logic                           q_bit;
    logic [CW-1:0]                  rem_next;
    logic [XW-1:0]                  quot_next;

    always_ff @(posedge clk_camera) begin
        if (recent_reset) begin
            valid_d <= 1'b0;
        end else begin
            valid_d <= pix.valid;
        end
    end

    always_ff @(posedge clk_camera) begin
        hcount_d <= pix.hcount;
        vcount_d <= pix.vcount;
    end

    assign hit       = valid_d && (&mask_i);  // passes all three channels
    assign cnt_next  = count + CW'(hit);
    assign sumx_next = hit ? sum_x + XW'(hcount_d) : sum_x;
    assign sumy_next = hit ? sum_y + YW'(vcount_d) : sum_y;

    always_ff @(posedge clk_camera) begin
        if (recent_reset || pix.frame_end) begin
            count <= '0;  // frame_end hands the totals to the divider
            sum_x <= '0;
            sum_y <= '0;
        end else begin
            count <= cnt_next;
            sum_x <= sumx_next;
            sum_y <= sumy_next;
        end
    end

    // restoring division step
    assign rem_shift = {div_rem, div_dividend[XW-1]};
    assign q_bit     = rem_shift >= {1'b0, div_divisor};
    assign rem_diff  = rem_shift - {1'b0, div_divisor};
    assign rem_next  = q_bit ? rem_diff[CW-1:0] : rem_shift[CW-1:0];
    assign quot_next = {div_dividend[XW-2:0], q_bit};
    assign last_step = step == tracker_pkg::DIV_CNT_W'(tracker_pkg::DIV_STEPS - 1);

    always_ff @(posedge clk_camera) begin
        if (recent_reset) begin
            state       <= tracker_pkg::idle;
            step        <= '0;
            com_x_o     <= '0;
            com_y_o     <= '0;
            com_valid_o <= 1'b0;
        end else begin
            com_valid_o <= 1'b0;
            case (state)
                tracker_pkg::idle: begin
                    step <= '0;
                    if (pix.frame_end && cnt_next != '0) begin  // empty frame, no result
                        state <= tracker_pkg::divide_x;
                    end
                end
                tracker_pkg::divide_x: begin
                    step <= step + 1'b1;  // wraps to 0 for the y pass
                    if (last_step) begin
                        com_x_o <= quot_next[tracker_pkg::HCOUNT_W-1:0];
                        state   <= tracker_pkg::divide_y;
                    end
                end
                tracker_pkg::divide_y: begin
                    step <= step + 1'b1;
                    if (last_step) begin
                        com_y_o     <= quot_next[tracker_pkg::VCOUNT_W-1:0];
                        com_valid_o <= 1'b1;
                        state       <= tracker_pkg::idle;
                    end
                end
                default: state <= tracker_pkg::idle;
            endcase
        end
    end

    // divider datapath, loaded from idle and between the two passes
    always_ff @(posedge clk_camera) begin
        case (state)
            tracker_pkg::idle: begin
                if (pix.frame_end) begin
                    div_divisor  <= cnt_next;
                    div_dividend <= sumx_next;
                    sum_y_hold   <= sumy_next;
                    div_rem      <= '0;
                end
            end
            tracker_pkg::divide_x: begin
                if (last_step) begin
                    div_dividend <= XW'(sum_y_hold);  // same divisor for y
                    div_rem      <= '0;
                end else begin
                    div_dividend <= quot_next;
                    div_rem      <= rem_next;
                end
            end
            tracker_pkg::divide_y: begin
                div_dividend <= quot_next;
                div_rem      <= rem_next;
            end
            default: div_rem <= '0;
        endcase
    end

    // no back-pressure toward capture, a frame must not end mid-division
    assert property (@(posedge clk_camera) disable iff (recent_reset)
        pix.frame_end |-> state == tracker_pkg::idle);

endmodule

// File: hw/channel_threshold.sv
`timescale 1ns/1ns

module channel_threshold (
    input  logic                           clk_camera,
    input  logic                           recent_reset,
    pixel_if.sink                          pix,
    input  tracker_pkg::channel_e          channel,
    input  logic [tracker_pkg::CHAN_W-1:0] lower_i,
    input  logic [tracker_pkg::CHAN_W-1:0] upper_i,
    output logic                           mask_o
);

    logic [tracker_pkg::CHAN_W-1:0] chan_val;  // field padded with zeros at the bottom
    logic                           in_window;

    always_comb begin
        case (channel)
            tracker_pkg::ch_red:
                chan_val = {pix.pixel[tracker_pkg::RED_MSB:tracker_pkg::RED_LSB],
                            {tracker_pkg::RED_PAD{1'b0}}};
            tracker_pkg::ch_green:
                chan_val = {pix.pixel[tracker_pkg::GREEN_MSB:tracker_pkg::GREEN_LSB],
                            {tracker_pkg::GREEN_PAD{1'b0}}};
            tracker_pkg::ch_blue:
                chan_val = {pix.pixel[tracker_pkg::BLUE_MSB:tracker_pkg::BLUE_LSB],
                            {tracker_pkg::BLUE_PAD{1'b0}}};
            default: chan_val = '0;  // unused index
        endcase
    end

    // both bounds inclusive
    assign in_window = (chan_val >= lower_i) && (chan_val <= upper_i);

    always_ff @(posedge clk_camera) begin
        if (recent_reset) begin
            mask_o <= 1'b0;
        end else begin
            mask_o <= pix.valid && in_window;  // one cycle behind the pixel
        end
    end

endmodule

// File: hw/pixel_capture.sv
`timescale 1ns/1ns

module pixel_capture (
    input  logic       clk_camera,
    input  logic       recent_reset,
    input  logic       cam_pclk_i,
    input  logic       cam_hsync_i,
    input  logic       cam_vsync_i,
    input  logic [7:0] cam_data_i,
    pixel_if.source    pix
);

    localparam int SS = tracker_pkg::SYNC_STAGES;

    logic [SS-1:0] pclk_sync;   // oldest sample in the top bit
    logic [SS-1:0] hsync_sync;
    logic [SS-1:0] vsync_sync;
    logic [7:0]    data_sync [SS];

    logic       pclk_s, hsync_s, vsync_s;  // synchronized camera bus
    logic [7:0] data_s;
    logic       pclk_d, hsync_d, vsync_d;  // one sample older for edge detection
    logic       pclk_rise;
    logic       hsync_fall;
    logic       vsync_rise;

    logic [7:0]                  high_byte;  // first byte of the pair
    tracker_pkg::capture_state_e state;

    always_ff @(posedge clk_camera) begin
        if (recent_reset) begin
            pclk_sync  <= '0;
            hsync_sync <= '0;
            vsync_sync <= '0;
        end else begin
            pclk_sync  <= {pclk_sync[SS-2:0], cam_pclk_i};
            hsync_sync <= {hsync_sync[SS-2:0], cam_hsync_i};
            vsync_sync <= {vsync_sync[SS-2:0], cam_vsync_i};
        end
    end

    // data bus delayed by the same number of stages as pclk
    always_ff @(posedge clk_camera) begin
        data_sync[0] <= cam_data_i;
        for (int i = 1; i < SS; i++) begin
            data_sync[i] <= data_sync[i-1];
        end
    end

    assign pclk_s  = pclk_sync[SS-1];
    assign hsync_s = hsync_sync[SS-1];
    assign vsync_s = vsync_sync[SS-1];
    assign data_s  = data_sync[SS-1];

    always_ff @(posedge clk_camera) begin
        if (recent_reset) begin
            pclk_d  <= 1'b0;
            hsync_d <= 1'b0;
            vsync_d <= 1'b0;
        end else begin
            pclk_d  <= pclk_s;
            hsync_d <= hsync_s;
            vsync_d <= vsync_s;
        end
    end

    assign pclk_rise  = pclk_s & ~pclk_d;
    assign hsync_fall = ~hsync_s & hsync_d;  // end of a line
    assign vsync_rise = vsync_s & ~vsync_d;  // end of a frame

    // byte phase restarts at the high byte whenever hsync drops
    always_ff @(posedge clk_camera) begin
        if (recent_reset) begin
            state     <= tracker_pkg::wait_high;
            pix.valid <= 1'b0;
        end else begin
            pix.valid <= 1'b0;
            if (!hsync_s) begin
                state <= tracker_pkg::wait_high;
            end else if (pclk_rise) begin
                case (state)
                    tracker_pkg::wait_high: state <= tracker_pkg::wait_low;
                    tracker_pkg::wait_low: begin
                        state     <= tracker_pkg::wait_high;
                        pix.valid <= 1'b1;  // strobe lands with the assembled pixel
                    end
                    default: state <= tracker_pkg::wait_high;
                endcase
            end
        end
    end

    always_ff @(posedge clk_camera) begin
        if (pclk_rise && hsync_s) begin
            if (state == tracker_pkg::wait_high) begin
                high_byte <= data_s;
            end else begin
                pix.pixel <= {high_byte, data_s};
            end
        end
    end

    // column, row and frame-end pulse
    always_ff @(posedge clk_camera) begin
        if (recent_reset) begin
            pix.hcount    <= '0;
            pix.vcount    <= '0;
            pix.frame_end <= 1'b0;
        end else begin
            pix.frame_end <= vsync_rise;
            if (!hsync_s) begin
                pix.hcount <= '0;                 // blanking so the next line starts at 0
            end else if (pix.valid) begin
                pix.hcount <= pix.hcount + 1'b1;  // advance after each pixel
            end
            if (vsync_s) begin
                pix.vcount <= '0;
            end else if (hsync_fall) begin
                pix.vcount <= pix.vcount + 1'b1;
            end
        end
    end

    // pclk rises at least four clk_camera cycles apart, which keeps valid strobes apart
    assert property (@(posedge clk_camera) disable iff (recent_reset)
        pclk_rise |-> !$past(pclk_rise, 2) && !$past(pclk_rise, 3));

endmodule

// File: hw/pixel_if.sv
`timescale 1ns/1ns

// reconstructed pixel stream, capture -> thresholders and centroid
interface pixel_if;

    logic                             valid;      // one-cycle strobe per pixel
    logic [tracker_pkg::PIXEL_W-1:0]  pixel;      // 5:6:5
    logic [tracker_pkg::HCOUNT_W-1:0] hcount;     // column
    logic [tracker_pkg::VCOUNT_W-1:0] vcount;     // row
    logic                             frame_end;  // one-cycle pulse after vsync rises

    modport source (
        output valid,
        output pixel,
        output hcount,
        output vcount,
        output frame_end
    );

    modport sink (
        input valid,
        input pixel,
        input hcount,
        input vcount,
        input frame_end
    );

endinterface

// File: hw/tracker_pkg.sv
package tracker_pkg;

    localparam int NUM_CHANNELS = 3;   // red, green, blue
    localparam int HCOUNT_W     = 11;  // column
    localparam int VCOUNT_W     = 10;  // row
    localparam int PIXEL_W      = 16;  // 5:6:5 pixel
    localparam int CHAN_W       = 8;   // expanded channel and bounds
    localparam int COUNT_W      = 21;  // masked pixels per frame
    localparam int SUMX_W       = 32;  // column sum
    localparam int SUMY_W       = 31;  // row sum
    localparam int SYNC_STAGES  = 2;   // camera input synchronizer depth

    // one quotient bit per cycle, over the widest dividend
    localparam int DIV_STEPS = SUMX_W;
    localparam int DIV_CNT_W = $clog2(DIV_STEPS);

    // channel index, also the order of the fields inside the pixel
    typedef enum logic [1:0] {
        ch_blue  = 2'd0,
        ch_green = 2'd1,
        ch_red   = 2'd2
    } channel_e;

    // field slices of the 5:6:5 pixel, and the zero fill up to CHAN_W
    localparam int RED_MSB   = 15;
    localparam int RED_LSB   = 11;
    localparam int GREEN_MSB = 10;
    localparam int GREEN_LSB = 5;
    localparam int BLUE_MSB  = 4;
    localparam int BLUE_LSB  = 0;
    localparam int RED_PAD   = CHAN_W - (RED_MSB - RED_LSB + 1);
    localparam int GREEN_PAD = CHAN_W - (GREEN_MSB - GREEN_LSB + 1);
    localparam int BLUE_PAD  = CHAN_W - (BLUE_MSB - BLUE_LSB + 1);

    typedef enum logic {
        wait_high,  // next byte is the upper half
        wait_low    // next byte completes the pixel
    } capture_state_e;

    typedef enum logic [1:0] {
        idle,
        divide_x,
        divide_y
    } centroid_state_e;

endpackage
